// File: hw/pathSortPkg.sv
package pathSortPkg;

	typedef logic [7:0] coordT;	// one grid axis

	// y is declared first so it lands in the upper byte of the bus word
	typedef struct packed {
		coordT y;
		coordT x;
	} nodeT;

	typedef logic [11:0] costT;	// wide enough for 14 * 255

	// octile step weights
	localparam costT CostStraight = 12'd10;
	localparam costT CostDiagonal = 12'd14;

	//////////////////////////////
	// register map
	localparam logic [11:0] CtrlAddr = 12'h000;
	localparam logic [11:0] StatusAddr = 12'h004;
	localparam logic [11:0] GoalAddr = 12'h008;
	localparam logic [11:0] CountAddr = 12'h00C;
	localparam logic [11:0] NodeBase = 12'h100;	// node i at NodeBase + 4*i

	typedef enum logic [2:0] {
		Idle,
		Fetch,
		Compare,
		Advance,
		Finish
	} sortStateT;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

endpackage

// File: hw/openListIf.sv
`timescale 1ns/1ps

interface openListIf #(
	parameter int ListDepth = 16
);
	import pathSortPkg::*;

	localparam int IdxW = $clog2(ListDepth);

	// neighbour pair seen by the sorter
	logic [IdxW-1:0] Index;
	logic SwapEn;
	nodeT NodeLo;	// entry at Index
	nodeT NodeHi;	// entry at Index+1

	// single entry port for the register block
	logic [IdxW-1:0] HostIndex;
	logic HostWrite;
	nodeT HostWrData;
	nodeT HostRdData;

	modport store (input Index, SwapEn, HostIndex, HostWrite, HostWrData,
		output NodeLo, NodeHi, HostRdData);
	modport sorter (output Index, SwapEn);
	modport host (output HostIndex, HostWrite, HostWrData,
		input HostRdData);

endinterface

// File: hw/openListStore.sv
`timescale 1ns/1ps

module openListStore #(
	parameter int ListDepth = 16
) (
	input logic Clk,
	input logic Reset,
	openListIf.store list
);
	import pathSortPkg::*;

	localparam int IdxW = $clog2(ListDepth);

	nodeT nodes [ListDepth];
	logic [IdxW:0] hiIndex;	// one bit wider so Index+1 cannot wrap

	assign hiIndex = {1'b0, list.Index} + 1'b1;

	// all reads are combinational
	always_comb
	begin
		list.NodeLo = nodes[list.Index];
		list.NodeHi = (hiIndex < ListDepth) ? nodes[hiIndex[IdxW-1:0]] : '0;
		list.HostRdData = (list.HostIndex < ListDepth) ? nodes[list.HostIndex] : '0;
	end

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			for (int i = 0; i < ListDepth; i++)
				nodes[i] <= '0;
		end
		else if (list.SwapEn)
		begin
			// exchange the neighbour pair
			nodes[list.Index] <= list.NodeHi;
			nodes[hiIndex[IdxW-1:0]] <= list.NodeLo;
		end
		else if (list.HostWrite)
		begin
			nodes[list.HostIndex] <= list.HostWrData;
		end
	end

	//////////////////////////////
	// the sorter must keep its pair inside the array
	assert property (@(posedge Clk) disable iff (Reset)
		list.SwapEn |-> (hiIndex < ListDepth));

	// swaps and host writes come from two different blocks and must never meet
	assert property (@(posedge Clk) disable iff (Reset)
		!(list.SwapEn && list.HostWrite));

endmodule

// File: hw/octileCost.sv
`timescale 1ns/1ps

module octileCost (
	input logic Clk,
	input logic Reset,
	input pathSortPkg::nodeT NodeLo,
	input pathSortPkg::nodeT NodeHi,
	input pathSortPkg::nodeT Goal,
	output pathSortPkg::costT CostLo,
	output pathSortPkg::costT CostHi
);
	import pathSortPkg::*;

	// diagonal steps cover the shorter axis, straight steps the rest
	function automatic costT octile(input nodeT a, input nodeT b);
		costT dx;
		costT dy;
		costT dMin;
		costT dMax;
		dx = (a.x > b.x) ? costT'(a.x - b.x) : costT'(b.x - a.x);
		dy = (a.y > b.y) ? costT'(a.y - b.y) : costT'(b.y - a.y);
		dMin = (dx < dy) ? dx : dy;
		dMax = (dx < dy) ? dy : dx;
		return CostDiagonal * dMin + CostStraight * (dMax - dMin);
	endfunction

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			CostLo <= '0;
			CostHi <= '0;
		end
		else
		begin
			CostLo <= octile(NodeLo, Goal);
			CostHi <= octile(NodeHi, Goal);
		end
	end

endmodule

// File: hw/cocktailSortCtrl.sv
`timescale 1ns/1ps

module cocktailSortCtrl #(
	parameter int ListDepth = 16
) (
	input logic Clk,
	input logic Reset,
	input logic Start,
	input logic [$clog2(ListDepth+1)-1:0] Count,
	input pathSortPkg::costT CostLo,
	input pathSortPkg::costT CostHi,
	output logic Busy,
	output logic Done,
	openListIf.sorter list
);
	import pathSortPkg::*;

	localparam int IdxW = $clog2(ListDepth);
	localparam int CntW = $clog2(ListDepth + 1);

	sortStateT state;
	logic forward;	// pass direction
	logic swapped;	// any exchange in the current pass
	logic [IdxW-1:0] lastIdx;	// highest pair index, Count-2

	assign lastIdx = IdxW'(Count - CntW'(2));
	assign Busy = (state != Idle);

	// strict compare keeps equal costs in load order
	assign list.SwapEn = (state == Compare) && (CostLo > CostHi);

	//////////////////////////////
	// pass sequencing
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= Idle;
			list.Index <= '0;
			forward <= 1'b1;
			swapped <= 1'b0;
			Done <= 1'b0;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (Start)
					begin
						Done <= 1'b0;
						list.Index <= '0;
						forward <= 1'b1;
						swapped <= 1'b0;
						// nothing to order with fewer than two nodes
						state <= (Count < CntW'(2)) ? Finish : Fetch;
					end
				end
				Fetch:
					state <= Compare;	// cost pair registers on this edge
				Compare:
				begin
					if (list.SwapEn)
						swapped <= 1'b1;
					state <= Advance;
				end
				Advance:
				begin
					state <= Fetch;
					if (forward)
					begin
						if (list.Index != lastIdx)
							list.Index <= list.Index + 1'b1;
						else if (!swapped)
							state <= Finish;
						else
						begin
							// largest entry now sits at the top so start one below it
							forward <= 1'b0;
							swapped <= 1'b0;
							if (list.Index != '0)
								list.Index <= list.Index - 1'b1;
						end
					end
					else
					begin
						if (list.Index != '0)
							list.Index <= list.Index - 1'b1;
						else if (!swapped)
							state <= Finish;
						else
						begin
							forward <= 1'b1;	// smallest is settled at 0
							swapped <= 1'b0;
							if (list.Index != lastIdx)
								list.Index <= list.Index + 1'b1;
						end
					end
				end
				Finish:
				begin
					Done <= 1'b1;
					state <= Idle;
				end
				default:
					state <= Idle;
			endcase
		end
	end

	// the host never sees a sort that is both running and finished
	assert property (@(posedge Clk) disable iff (Reset) !(Busy && Done));

endmodule

// File: hw/axiLiteRegs.sv
`timescale 1ns/1ps

module axiLiteRegs #(
	parameter int ListDepth = 16
) (
	input logic Clk,
	input logic Reset,
	input logic [11:0] AwAddr,
	input logic AwValid,
	output logic AwReady,
	input logic [31:0] WData,
	input logic WValid,
	output logic WReady,
	output logic [1:0] BResp,
	output logic BValid,
	input logic BReady,
	input logic [11:0] ArAddr,
	input logic ArValid,
	output logic ArReady,
	output logic [31:0] RData,
	output logic [1:0] RResp,
	output logic RValid,
	input logic RReady,
	output pathSortPkg::nodeT Goal,
	output logic [$clog2(ListDepth+1)-1:0] Count,
	output logic Start,
	input logic Busy,
	input logic Done,
	openListIf.host list
);
	import pathSortPkg::*;

	localparam int IdxW = $clog2(ListDepth);
	localparam int CntW = $clog2(ListDepth + 1);

	logic idle;
	logic wrGo;
	logic rdGo;
	logic [11:0] wrOff;	// offsets into the node window
	logic [11:0] rdOff;
	logic wrNode;
	logic rdNode;
	logic [1:0] wrResp;
	logic [1:0] rdResp;
	logic [31:0] rdValue;

	// one transaction at a time, writes first
	assign idle = !(AwReady || ArReady || BValid || RValid);
	assign wrGo = idle && AwValid && WValid;
	assign rdGo = idle && ArValid && !wrGo;

	assign wrOff = AwAddr - NodeBase;
	assign rdOff = ArAddr - NodeBase;
	assign wrNode = (AwAddr >= NodeBase) && (wrOff[11:2] < ListDepth);
	assign rdNode = (ArAddr >= NodeBase) && (rdOff[11:2] < ListDepth);

	// the node port follows whichever address is being served
	assign list.HostIndex = AwReady ? wrOff[IdxW+1:2] : rdOff[IdxW+1:2];
	assign list.HostWrData = WData[15:0];
	assign list.HostWrite = AwReady && wrNode && !Busy;

	//////////////////////////////
	// decode
	always_comb
	begin
		wrResp = respOkay;
		if (wrNode || AwAddr == GoalAddr || AwAddr == CountAddr)
		begin
			if (Busy)
				wrResp = respSlvErr;	// locked while sorting
		end
		else if (AwAddr != CtrlAddr && AwAddr != StatusAddr)
			wrResp = respSlvErr;
	end

	always_comb
	begin
		rdValue = '0;
		rdResp = respOkay;
		if (rdNode)
			rdValue = {16'h0, list.HostRdData};
		else
		begin
			case (ArAddr)
				CtrlAddr: rdValue = '0;	// start is a pulse
				StatusAddr: rdValue = {30'h0, Done, Busy};
				GoalAddr: rdValue = {16'h0, Goal};
				CountAddr: rdValue = 32'(Count);
				default: rdResp = respSlvErr;
			endcase
		end
	end

	//////////////////////////////
	// handshakes and registers
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			AwReady <= 1'b0;
			WReady <= 1'b0;
			ArReady <= 1'b0;
			BValid <= 1'b0;
			RValid <= 1'b0;
			Start <= 1'b0;
			Goal <= '0;
			Count <= '0;
		end
		else
		begin
			AwReady <= wrGo;
			WReady <= wrGo;
			ArReady <= rdGo;
			Start <= 1'b0;
			if (AwReady)
				BValid <= 1'b1;
			else if (BReady)
				BValid <= 1'b0;
			if (ArReady)
				RValid <= 1'b1;
			else if (RReady)
				RValid <= 1'b0;
			if (AwReady && !Busy)
			begin
				case (AwAddr)
					CtrlAddr: Start <= WData[0];
					GoalAddr: Goal <= WData[15:0];
					CountAddr: Count <= (WData > ListDepth) ? CntW'(ListDepth) : CntW'(WData);
					default: Start <= 1'b0;
				endcase
			end
		end
	end

	// response payload only changes on a new handshake
	always_ff @(posedge Clk)
	begin
		if (AwReady)
			BResp <= wrResp;
		if (ArReady)
		begin
			RData <= rdValue;
			RResp <= rdResp;
		end
	end

	// node writes land only while the sorter is stopped and not about to start
	assert property (@(posedge Clk) disable iff (Reset)
		list.HostWrite |-> !(Busy || Start));

endmodule

// File: hw/openListSorter.sv
`timescale 1ns/1ps

module openListSorter #(
	parameter int ListDepth = 16
) (
	input logic Clk,
	input logic Reset,
	input logic [11:0] AwAddr,
	input logic AwValid,
	output logic AwReady,
	input logic [31:0] WData,
	input logic WValid,
	output logic WReady,
	output logic [1:0] BResp,
	output logic BValid,
	input logic BReady,
	input logic [11:0] ArAddr,
	input logic ArValid,
	output logic ArReady,
	output logic [31:0] RData,
	output logic [1:0] RResp,
	output logic RValid,
	input logic RReady
);
	import pathSortPkg::*;

	localparam int CntW = $clog2(ListDepth + 1);

	nodeT goal;
	logic [CntW-1:0] count;
	logic start;
	logic busy;
	logic done;
	costT costLo;
	costT costHi;

	openListIf #(.ListDepth(ListDepth)) list ();

	openListStore #(.ListDepth(ListDepth)) store (
		.Clk(Clk),
		.Reset(Reset),
		.list(list.store)
	);

	// cost of the current neighbour pair
	octileCost cost (
		.Clk(Clk),
		.Reset(Reset),
		.NodeLo(list.NodeLo),
		.NodeHi(list.NodeHi),
		.Goal(goal),
		.CostLo(costLo),
		.CostHi(costHi)
	);

	cocktailSortCtrl #(.ListDepth(ListDepth)) sortCtrl (
		.Clk(Clk),
		.Reset(Reset),
		.Start(start),
		.Count(count),
		.CostLo(costLo),
		.CostHi(costHi),
		.Busy(busy),
		.Done(done),
		.list(list.sorter)
	);

	axiLiteRegs #(.ListDepth(ListDepth)) regs (
		.Clk(Clk),
		.Reset(Reset),
		.AwAddr(AwAddr),
		.AwValid(AwValid),
		.AwReady(AwReady),
		.WData(WData),
		.WValid(WValid),
		.WReady(WReady),
		.BResp(BResp),
		.BValid(BValid),
		.BReady(BReady),
		.ArAddr(ArAddr),
		.ArValid(ArValid),
		.ArReady(ArReady),
		.RData(RData),
		.RResp(RResp),
		.RValid(RValid),
		.RReady(RReady),
		.Goal(goal),
		.Count(count),
		.Start(start),
		.Busy(busy),
		.Done(done),
		.list(list.host)
	);

endmodule

// File: testbench/tbAxiTasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

//////////////////////////////
// AXI4-Lite master side

// one write, then a random stall before the response is taken
task automatic writeTransfer(input logic [11:0] addr, input logic [31:0] data,
	output logic [1:0] resp);
	int waited;
	int stall;
	AwAddr = addr;
	AwValid = 1'b1;
	WData = data;
	WValid = 1'b1;
	waited = 0;
	while (!(AwReady && WReady))
	begin
		tick();
		waited++;
		if (waited > HandshakeTimeout)
			abortRun("write address and data were never accepted");
	end
	tick();	// handshake edge
	AwValid = 1'b0;
	WValid = 1'b0;
	waited = 0;
	while (!BValid)
	begin
		tick();
		waited++;
		if (waited > HandshakeTimeout)
			abortRun("write response never arrived");
	end
	resp = BResp;
	stall = $urandom_range(maxStall, 0);
	repeat (stall)
	begin
		tick();
		assert (BValid === 1'b1)
		else abortRun("BVALID fell before BREADY was raised");
		assert (BResp === resp)
		else abortRun($sformatf("ERR BRESP expected 0x%h got 0x%h", resp, BResp));
	end
	BReady = 1'b1;
	tick();
	BReady = 1'b0;
endtask

// one read, response held back the same way
task automatic readTransfer(input logic [11:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	int waited;
	int stall;
	ArAddr = addr;
	ArValid = 1'b1;
	waited = 0;
	while (!ArReady)
	begin
		tick();
		waited++;
		if (waited > HandshakeTimeout)
			abortRun("read address was never accepted");
	end
	tick();
	ArValid = 1'b0;
	waited = 0;
	while (!RValid)
	begin
		tick();
		waited++;
		if (waited > HandshakeTimeout)
			abortRun("read data never arrived");
	end
	data = RData;
	resp = RResp;
	stall = $urandom_range(maxStall, 0);
	repeat (stall)
	begin
		tick();
		assert (RValid === 1'b1)
		else abortRun("RVALID fell before RREADY was raised");
		assert (RData === data)
		else abortRun($sformatf("ERR RDATA expected 0x%h got 0x%h", data, RData));
		assert (RResp === resp)
		else abortRun($sformatf("ERR RRESP expected 0x%h got 0x%h", resp, RResp));
	end
	RReady = 1'b1;
	tick();
	RReady = 1'b0;
endtask

`endif

// File: testbench/tbOpenListSorter.sv
`timescale 1ns/1ps

module tbOpenListSorter;
	import pathSortPkg::*;

	localparam int HandshakeTimeout = 40;	// cycles per channel
	localparam int DonePolls = 400;

	logic Clk;
	logic Reset;
	logic [11:0] AwAddr;
	logic AwValid;
	logic AwReady;
	logic [31:0] WData;
	logic WValid;
	logic WReady;
	logic [1:0] BResp;
	logic BValid;
	logic BReady;
	logic [11:0] ArAddr;
	logic ArValid;
	logic ArReady;
	logic [31:0] RData;
	logic [1:0] RResp;
	logic RValid;
	logic RReady;

	logic [15:0] model [16];	// expected store contents
	string nameQ [$];
	logic [31:0] expQ [$];
	logic [31:0] gotQ [$];
	int maxStall;
	string cmpName;
	logic [31:0] cmpExp;
	logic [31:0] cmpGot;

	openListSorter #(.ListDepth(16)) uut (.*);

	always #4 Clk = ~Clk;

	task automatic tick();
		@(posedge Clk);
		#1;
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at first failure");
	endtask

	`include "tbAxiTasks.svh"

	//////////////////////////////
	// reference model

	// 14 per diagonal step, 10 per straight step
	function automatic int heuristic(input logic [15:0] node, input logic [15:0] goal);
		int dx;
		int dy;
		dx = int'(node[7:0]) - int'(goal[7:0]);
		dy = int'(node[15:8]) - int'(goal[15:8]);
		if (dx < 0)
			dx = -dx;
		if (dy < 0)
			dy = -dy;
		if (dx < dy)
			return 14 * dx + 10 * (dy - dx);
		return 14 * dy + 10 * (dx - dy);
	endfunction

	// insertion sort, stable on equal cost
	function automatic void sortReference(input int count, input logic [15:0] goal);
		logic [15:0] key;
		int j;
		for (int i = 1; i < count; i++)
		begin
			key = model[i];
			j = i - 1;
			while (j >= 0 && heuristic(model[j], goal) > heuristic(key, goal))
			begin
				model[j + 1] = model[j];
				j--;
			end
			model[j + 1] = key;
		end
	endfunction

	// compare process, drains whatever the stimulus queued
	always @(posedge Clk)
	begin
		while (gotQ.size() != 0)
		begin
			cmpName = nameQ.pop_front();
			cmpExp = expQ.pop_front();
			cmpGot = gotQ.pop_front();
			assert (cmpGot === cmpExp)
			else abortRun($sformatf("ERR %s expected 0x%h got 0x%h", cmpName, cmpExp, cmpGot));
		end
	end

	//////////////////////////////
	// stimulus helpers
	task automatic queueCheck(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		nameQ.push_back(name);
		expQ.push_back(expected);
		gotQ.push_back(actual);
	endtask

	task automatic writeAndCheck(input logic [11:0] addr, input logic [31:0] data,
		input logic [1:0] expResp);
		logic [1:0] resp;
		writeTransfer(addr, data, resp);
		queueCheck($sformatf("BRESP at 0x%h", addr), 32'(expResp), 32'(resp));
	endtask

	task automatic readAndCheck(input logic [11:0] addr, input logic [31:0] expData,
		input logic [1:0] expResp);
		logic [31:0] data;
		logic [1:0] resp;
		readTransfer(addr, data, resp);
		queueCheck($sformatf("RRESP at 0x%h", addr), 32'(expResp), 32'(resp));
		queueCheck($sformatf("RDATA at 0x%h", addr), expData, data);
	endtask

	task automatic randomList(input int count);
		for (int i = 0; i < count; i++)
			model[i] = 16'($urandom);
	endtask

	// eight nodes at cost 44 around goal (100,100), mixed with other costs
	task automatic buildTieList();
		int dx [12] = '{4, 1, 6, -4, -1, 0, 4, 1, 1, -4, -1, -2};
		int dy [12] = '{1, 4, 6, 1, 4, 2, -1, -4, 0, -1, -4, 0};
		for (int i = 0; i < 12; i++)
			model[i] = {8'(100 + dy[i]), 8'(100 + dx[i])};
	endtask

	task automatic loadList(input int count, input logic [15:0] goal);
		for (int i = 0; i < count; i++)
			writeAndCheck(NodeBase + 12'(4 * i), {16'h0, model[i]}, respOkay);
		writeAndCheck(GoalAddr, {16'h0, goal}, respOkay);
		writeAndCheck(CountAddr, 32'(count), respOkay);
	endtask

	task automatic checkList();
		for (int i = 0; i < 16; i++)
			readAndCheck(NodeBase + 12'(4 * i), {16'h0, model[i]}, respOkay);
	endtask

	task automatic waitDone();
		logic [31:0] data;
		logic [1:0] resp;
		int polls;
		polls = 0;
		readTransfer(StatusAddr, data, resp);
		while (data[1] !== 1'b1)
		begin
			polls++;
			if (polls > DonePolls)
				abortRun("sort never reported Done");
			readTransfer(StatusAddr, data, resp);
		end
		queueCheck("STATUS after Done", 32'h2, data);	// Busy already low
	endtask

	task automatic runSort(input int count, input logic [15:0] goal);
		writeAndCheck(CtrlAddr, 32'h1, respOkay);
		waitDone();
		sortReference(count, goal);
		checkList();
	endtask

	//////////////////////////////
	initial
	begin
		int count;
		logic [15:0] goal;
		logic [15:0] held;
		Clk = 1'b0;
		Reset = 1'b1;
		AwAddr = '0;
		AwValid = 1'b0;
		WData = '0;
		WValid = 1'b0;
		BReady = 1'b0;
		ArAddr = '0;
		ArValid = 1'b0;
		RReady = 1'b0;
		maxStall = 5;
		void'($urandom(32'h2f3564d1));
		for (int i = 0; i < 16; i++)
			model[i] = '0;
		repeat (4) @(posedge Clk);
		#1;
		Reset = 1'b0;

		// state after reset
		readAndCheck(StatusAddr, 32'h0, respOkay);
		checkList();

		// plain register access
		model[0] = 16'h1234;
		model[7] = 16'hbeef;
		model[15] = 16'h00ff;
		writeAndCheck(NodeBase, {16'h0, model[0]}, respOkay);
		writeAndCheck(NodeBase + 12'h1c, {16'h0, model[7]}, respOkay);
		writeAndCheck(NodeBase + 12'h3c, {16'h0, model[15]}, respOkay);
		checkList();
		writeAndCheck(GoalAddr, 32'h0000_3c2a, respOkay);
		readAndCheck(GoalAddr, 32'h0000_3c2a, respOkay);
		writeAndCheck(CountAddr, 32'd9, respOkay);
		readAndCheck(CountAddr, 32'd9, respOkay);
		writeAndCheck(CountAddr, 32'd20, respOkay);
		readAndCheck(CountAddr, 32'd16, respOkay);	// clamped
		writeAndCheck(12'h010, 32'h5, respSlvErr);
		readAndCheck(12'h010, 32'h0, respSlvErr);
		readAndCheck(NodeBase + 12'h40, 32'h0, respSlvErr);	// one past the last node

		repeat (20)
		begin
			count = $urandom_range(16, 2);
			goal = 16'($urandom);
			randomList(count);
			loadList(count, goal);
			runSort(count, goal);
		end

		// equal costs keep load order
		buildTieList();
		loadList(12, 16'h6464);
		runSort(12, 16'h6464);

		// presorted, then the same list reversed
		goal = 16'($urandom);
		randomList(16);
		sortReference(16, goal);
		loadList(16, goal);
		runSort(16, goal);
		for (int i = 0; i < 8; i++)
		begin
			held = model[i];
			model[i] = model[15 - i];
			model[15 - i] = held;
		end
		loadList(16, goal);
		runSort(16, goal);

		// short lists do nothing
		randomList(1);
		loadList(1, goal);
		runSort(1, goal);
		loadList(0, goal);
		runSort(0, goal);

		//////////////////////////////
		// lock-out while the sort runs
		goal = 16'($urandom);
		randomList(16);
		loadList(16, goal);
		maxStall = 0;	// keep the bus fast so the sort is still running
		writeAndCheck(CtrlAddr, 32'h1, respOkay);
		readAndCheck(StatusAddr, 32'h1, respOkay);
		writeAndCheck(NodeBase + 12'h0c, 32'h0000_5555, respSlvErr);
		writeAndCheck(GoalAddr, 32'h0000_0101, respSlvErr);
		writeAndCheck(CountAddr, 32'd3, respSlvErr);
		writeAndCheck(CtrlAddr, 32'h1, respOkay);	// restart ignored
		maxStall = 5;
		waitDone();
		sortReference(16, goal);
		checkList();
		readAndCheck(GoalAddr, {16'h0, goal}, respOkay);
		readAndCheck(CountAddr, 32'd16, respOkay);

		tick();
		tick();
		if (gotQ.size() == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
			abortRun("some readbacks were never compared");
	end

endmodule

// File: compile.f
+incdir+testbench
hw/pathSortPkg.sv
hw/openListIf.sv
hw/openListStore.sv
hw/octileCost.sv
hw/cocktailSortCtrl.sv
hw/axiLiteRegs.sv
hw/openListSorter.sv
testbench/tbOpenListSorter.sv

// File: Bender.yml
package:
  name: open_list_sorter

sources:
  - hw/pathSortPkg.sv
  - hw/openListIf.sv
  - hw/openListStore.sv
  - hw/octileCost.sv
  - hw/cocktailSortCtrl.sv
  - hw/axiLiteRegs.sv
  - hw/openListSorter.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbOpenListSorter.sv
